// ==== hw/ppu_fetch.sv ====
module ppu_fetch (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::ppu_mode_e  mode,
	input  logic [7:0]          ly,
	input  logic [7:0]          scy,
	input  logic [7:0]          scx,
	input  logic                bg_map,
	input  logic                bg_tiles,
	input  logic [7:0]          data,
	input  logic                row_take,
	output logic [15:0]         adr,
	output logic                read,
	output logic [7:0]          row_lo,
	output logic [7:0]          row_hi,
	output logic                row_valid
);

	ppu_pkg::fetch_state_e state;
	logic                  active;
	logic [7:0]            line;      // Background line after vertical scroll
	logic [15:0]           map_base;
	logic [15:0]           map_start;
	logic [15:0]           map_adr;   // Current tile map entry
	logic [7:0]            tile_idx;
	logic [15:0]           tile_adr;
	logic [15:0]           row_adr;   // Low byte of the tile row

	assign active   = mode == ppu_pkg::PXTRANS;
	assign line     = scy + ly;
	assign map_base = bg_map ? ppu_pkg::MAP_BASE_1 : ppu_pkg::MAP_BASE_0;

	// First map entry of the line
	assign map_start = {map_base[15:10], line[7:3], scx[7:3]};

	// Flipping bit 7 turns the signed index into an offset from 8800
	assign tile_idx = bg_tiles ? data : data ^ 8'h80;
	assign tile_adr = (bg_tiles ? ppu_pkg::TILE_BASE_1 : ppu_pkg::TILE_BASE_0) +
		{4'h0, tile_idx, line[2:0], 1'b0};

	assign row_valid = state == ppu_pkg::BLOCK;

	//////////////////////////////////////////////////////////////////////
	// VRAM port

	always_comb begin
		adr  = map_adr;
		read = 1'b0;
		case (state)
			ppu_pkg::IDLE:   read = active; // Tile number
			ppu_pkg::LO_ADR: begin
				read = active;
				adr  = row_adr;
			end
			ppu_pkg::HI_ADR: begin
				read = active;
				adr  = {row_adr[15:1], 1'b1};
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch FSM

	always_ff @(posedge clk) begin
		if (reset || !active) begin
			state <= ppu_pkg::IDLE;
		end else begin
			case (state)
				ppu_pkg::IDLE:    state <= ppu_pkg::TILE;
				ppu_pkg::TILE:    state <= ppu_pkg::LO_ADR;
				ppu_pkg::LO_ADR:  state <= ppu_pkg::LO_DATA;
				ppu_pkg::LO_DATA: state <= ppu_pkg::HI_ADR;
				ppu_pkg::HI_ADR:  state <= ppu_pkg::HI_DATA;
				ppu_pkg::HI_DATA: state <= ppu_pkg::BLOCK;
				ppu_pkg::BLOCK:
					if (row_take)
						state <= ppu_pkg::IDLE; // Otherwise wait for the FIFO
				default:          state <= ppu_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!active)
			map_adr <= map_start; // Ready for the entry into mode 3
		else if (row_take)
			map_adr[4:0] <= map_adr[4:0] + 5'd1; // Column wraps within the map row
		if (state == ppu_pkg::TILE)
			row_adr <= tile_adr;
		if (state == ppu_pkg::LO_DATA)
			row_lo <= data;
		if (state == ppu_pkg::HI_DATA)
			row_hi <= data;
	end

endmodule

// ==== hw/ppu_fifo.sv ====
module ppu_fifo (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::ppu_mode_e  mode,
	input  logic [7:0]          scx,
	input  logic [7:0]          bgp,
	input  logic [7:0]          row_lo,
	input  logic [7:0]          row_hi,
	input  logic                row_valid,
	output logic                row_take,
	output logic                line_done,
	output logic                hsync,
	output logic                pclk,
	output logic [1:0]          px
);

	logic        active;
	logic [15:0] fifo_lo;    // Bit plane 0, leftmost pixel in bit 15
	logic [15:0] fifo_hi;    // Bit plane 1
	logic [15:0] lo_nxt;
	logic [15:0] hi_nxt;
	logic [4:0]  len;        // Queued entries, 0 .. 16
	logic [4:0]  len_nxt;
	logic [7:0]  px_cnt;     // Pixels shifted out in this line
	logic [7:0]  cnt_nxt;
	logic        scxed;      // Fine scroll discard done
	logic        scxed_nxt;
	logic        shift;
	logic        show;
	logic [1:0]  color;

	assign active    = mode == ppu_pkg::PXTRANS;
	assign row_take  = active && row_valid && (len == 5'd0 || len == 5'd8);
	assign line_done = active && px_cnt == ppu_pkg::LINE_PIXELS;

	// High from the start of mode 3 until the garbage pixels are gone
	assign hsync = active && !(scxed && px_cnt >= 8'd8);

	//////////////////////////////////////////////////////////////////////
	// Next FIFO state

	always_comb begin
		lo_nxt    = fifo_lo;
		hi_nxt    = fifo_hi;
		len_nxt   = len;
		cnt_nxt   = px_cnt;
		scxed_nxt = scxed;
		show      = 1'b0;

		// New row goes behind whatever is still queued
		if (row_take) begin
			if (len == 5'd0) begin
				lo_nxt[15:8] = row_lo;
				hi_nxt[15:8] = row_hi;
			end else begin
				lo_nxt[7:0] = row_lo;
				hi_nxt[7:0] = row_hi;
			end
			len_nxt = len + 5'd8;
		end

		shift = active && len_nxt > 5'd8 && px_cnt != ppu_pkg::LINE_PIXELS;

		case ({hi_nxt[15], lo_nxt[15]})
			2'd0:    color = bgp[1:0];
			2'd1:    color = bgp[3:2];
			2'd2:    color = bgp[5:4];
			default: color = bgp[7:6];
		endcase

		if (shift) begin
			// Drop SCX[2:0] pixels once, then count from zero again
			if (!scxed && px_cnt == {5'd0, scx[2:0]}) begin
				scxed_nxt = 1'b1;
				cnt_nxt   = 8'd0;
			end
			show    = scxed_nxt && cnt_nxt >= 8'd8;
			cnt_nxt = cnt_nxt + 8'd1;
			len_nxt = len_nxt - 5'd1;
			lo_nxt  = {lo_nxt[14:0], 1'b0};
			hi_nxt  = {hi_nxt[14:0], 1'b0};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registers

	always_ff @(posedge clk) begin
		if (reset || !active) begin
			len    <= 5'd8; // Each line opens with 8 garbage entries
			px_cnt <= 8'd0;
			scxed  <= 1'b0;
			pclk   <= 1'b0;
			px     <= 2'd0;
		end else begin
			len    <= len_nxt;
			px_cnt <= cnt_nxt;
			scxed  <= scxed_nxt;
			pclk   <= show;
			px     <= show ? color : 2'd0; // Valid while pclk is high
		end
	end

	always_ff @(posedge clk) begin
		fifo_lo <= lo_nxt;
		fifo_hi <= hi_nxt;
	end

endmodule

// ==== hw/ppu_pkg.sv ====
package ppu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Line and frame timing

	localparam logic [8:0] LINE_CYCLES       = 9'd456; // Clocks per line
	localparam logic [7:0] FRAME_LINES       = 8'd154;
	localparam logic [7:0] VISIBLE_LINES     = 8'd144; // First vblank line
	localparam logic [8:0] OAMSRC_CYCLES     = 9'd80;  // Mode 3 starts at this lx
	localparam logic [7:0] LINE_PIXELS       = 8'd168; // 8 garbage plus 160 shown
	localparam logic [8:0] LY_EARLY_RESET_LX = 9'd8;   // LY reads 0 from here in line 153

	//////////////////////////////////////////////////////////////////////
	// VRAM layout

	localparam logic [15:0] MAP_BASE_0  = 16'h9800;
	localparam logic [15:0] MAP_BASE_1  = 16'h9c00;
	localparam logic [15:0] TILE_BASE_0 = 16'h8800; // Signed tile index
	localparam logic [15:0] TILE_BASE_1 = 16'h8000;

	//////////////////////////////////////////////////////////////////////
	// Encodings

	// STAT bits 1..0
	typedef enum logic [1:0] {
		HBLANK  = 2'd0,
		VBLANK  = 2'd1,
		OAMSRC  = 2'd2,
		PXTRANS = 2'd3
	} ppu_mode_e;

	typedef enum logic [2:0] {
		IDLE,
		TILE,
		LO_ADR,
		LO_DATA,
		HI_ADR,
		HI_DATA,
		BLOCK
	} fetch_state_e;

	// Register offsets from FF40
	typedef enum logic [3:0] {
		LCDC = 4'h0,
		STAT = 4'h1,
		SCY  = 4'h2,
		SCX  = 4'h3,
		LY   = 4'h4,
		LYC  = 4'h5,
		BGP  = 4'h7,
		OBP0 = 4'h8,
		OBP1 = 4'h9,
		WY   = 4'ha,
		WX   = 4'hb
	} reg_addr_e;

endpackage

// ==== hw/ppu_regs.sv ====
module ppu_regs (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::reg_addr_e  reg_adr,
	input  logic [7:0]          reg_din,
	input  logic                reg_read,
	input  logic                reg_write,
	input  logic [7:0]          ly,
	input  ppu_pkg::ppu_mode_e  mode,
	input  logic                lyc_eq,
	output logic [7:0]          reg_dout,
	output logic                lcd_on,
	output logic                bg_map,
	output logic                bg_tiles,
	output logic                sel_lyc,
	output logic                sel_mode2,
	output logic                sel_mode1,
	output logic                sel_mode0,
	output logic [7:0]          scy,
	output logic [7:0]          scx,
	output logic [7:0]          lyc,
	output logic [7:0]          bgp
);

	logic       read_q;     // Strobe levels of the previous cycle
	logic       write_q;
	logic       read_rise;
	logic       write_fall;
	logic [7:0] lcdc;
	logic [3:0] stat_sel;   // STAT bits 6..3
	logic [7:0] obp0;
	logic [7:0] obp1;
	logic [7:0] wy;
	logic [7:0] wx;
	logic [7:0] rd_data;

	assign read_rise  = reg_read && !read_q;
	assign write_fall = write_q && !reg_write;

	assign lcd_on   = lcdc[7];
	assign bg_tiles = lcdc[4]; // 0 selects 8800-97ff
	assign bg_map   = lcdc[3]; // 0 selects 9800-9bff

	assign {sel_lyc, sel_mode2, sel_mode1, sel_mode0} = stat_sel;

	//////////////////////////////////////////////////////////////////////
	// Readback mux

	always_comb begin
		case (reg_adr)
			ppu_pkg::LCDC: rd_data = lcdc;
			ppu_pkg::STAT: rd_data = {1'b1, stat_sel, lyc_eq, mode};
			ppu_pkg::SCY:  rd_data = scy;
			ppu_pkg::SCX:  rd_data = scx;
			ppu_pkg::LY:   rd_data = ly;
			ppu_pkg::LYC:  rd_data = lyc;
			ppu_pkg::BGP:  rd_data = bgp;
			ppu_pkg::OBP0: rd_data = obp0;
			ppu_pkg::OBP1: rd_data = obp1;
			ppu_pkg::WY:   rd_data = wy;
			ppu_pkg::WX:   rd_data = wx;
			default:       rd_data = 8'hff; // Unmapped offsets
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Register file

	always_ff @(posedge clk) begin
		if (reset) begin
			read_q   <= 1'b0;
			write_q  <= 1'b0;
			reg_dout <= 8'h00;
			lcdc     <= 8'h00;
			stat_sel <= 4'h0;
			scy      <= 8'h00;
			scx      <= 8'h00;
			lyc      <= 8'h00;
			bgp      <= 8'h00;
			obp0     <= 8'h00;
			obp1     <= 8'h00;
			wy       <= 8'h00;
			wx       <= 8'h00;
		end else begin
			read_q  <= reg_read;
			write_q <= reg_write;
			if (read_rise)
				reg_dout <= rd_data; // Held until the next read
			// Store on the trailing edge of the write strobe
			if (write_fall) begin
				case (reg_adr)
					ppu_pkg::LCDC: lcdc     <= reg_din;
					ppu_pkg::STAT: stat_sel <= reg_din[6:3];
					ppu_pkg::SCY:  scy      <= reg_din;
					ppu_pkg::SCX:  scx      <= reg_din;
					ppu_pkg::LYC:  lyc      <= reg_din;
					ppu_pkg::BGP:  bgp      <= reg_din;
					ppu_pkg::OBP0: obp0     <= reg_din;
					ppu_pkg::OBP1: obp1     <= reg_din;
					ppu_pkg::WY:   wy       <= reg_din;
					ppu_pkg::WX:   wx       <= reg_din;
					default: ; // LY is read only
				endcase
			end
		end
	end

endmodule

// ==== hw/ppu_timing.sv ====
module ppu_timing (
	input  logic                clk,
	input  logic                reset,
	input  logic                lcd_on,
	input  logic [7:0]          lyc,
	input  logic                sel_lyc,
	input  logic                sel_mode2,
	input  logic                sel_mode1,
	input  logic                sel_mode0,
	input  logic                line_done,
	output ppu_pkg::ppu_mode_e  mode,
	output logic [7:0]          ly,
	output logic                lyc_eq,
	output logic                lx_zero,
	output logic                irq_vblank,
	output logic                irq_stat,
	output logic                vsync
);

	localparam logic [8:0] VSYNC_LX = 9'd6;

	logic [8:0]         lx;      // 0 .. 455
	logic [8:0]         lx_nxt;
	logic [7:0]         ily;     // Completes line 153 normally
	logic [7:0]         ily_nxt;
	logic [7:0]         ly_nxt;
	ppu_pkg::ppu_mode_e mode_nxt;
	logic               stat_cond;
	logic               stat_q;

	//////////////////////////////////////////////////////////////////////
	// Counters and mode sequence

	always_comb begin
		lx_nxt  = (lx == ppu_pkg::LINE_CYCLES - 9'd1) ? 9'd0 : lx + 9'd1;
		ily_nxt = ily;
		if (lx == ppu_pkg::LINE_CYCLES - 9'd1)
			ily_nxt = (ily == ppu_pkg::FRAME_LINES - 8'd1) ? 8'd0 : ily + 8'd1;

		// Visible LY wraps early in the last line of the frame
		ly_nxt = ily_nxt;
		if (ily_nxt == ppu_pkg::FRAME_LINES - 8'd1 && lx_nxt >= ppu_pkg::LY_EARLY_RESET_LX)
			ly_nxt = 8'd0;

		mode_nxt = mode;
		if (ily_nxt >= ppu_pkg::VISIBLE_LINES)
			mode_nxt = ppu_pkg::VBLANK;
		else if (lx_nxt < ppu_pkg::OAMSRC_CYCLES)
			mode_nxt = ppu_pkg::OAMSRC; // Idle slot kept for STAT
		else if (lx_nxt == ppu_pkg::OAMSRC_CYCLES)
			mode_nxt = ppu_pkg::PXTRANS;
		else if (line_done)
			mode_nxt = ppu_pkg::HBLANK;
	end

	always_ff @(posedge clk) begin
		if (reset || !lcd_on) begin
			lx     <= 9'd0;
			ily    <= 8'd0;
			ly     <= 8'd0;
			mode   <= ppu_pkg::HBLANK;
			lyc_eq <= 1'b0;
			stat_q <= 1'b0;
			vsync  <= 1'b0;
		end else begin
			lx     <= lx_nxt;
			ily    <= ily_nxt;
			ly     <= ly_nxt;
			mode   <= mode_nxt;
			lyc_eq <= ly == lyc; // One cycle behind LY
			stat_q <= stat_cond;
			if (lx_nxt == VSYNC_LX)
				vsync <= ily_nxt == 8'd0; // Spans line 0 into line 1
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Interrupts

	assign stat_cond = lcd_on && ((lyc_eq && sel_lyc) ||
		(mode == ppu_pkg::HBLANK && sel_mode0) ||
		(mode == ppu_pkg::VBLANK && (sel_mode1 || sel_mode2)) ||
		(mode == ppu_pkg::OAMSRC && sel_mode2));

	assign irq_stat   = stat_cond && !stat_q; // Rising edge only
	assign lx_zero    = lcd_on && lx == 9'd0;
	assign irq_vblank = lx_zero && ly == ppu_pkg::VISIBLE_LINES;

endmodule

// ==== hw/ppu_top.sv ====
module ppu_top (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::reg_addr_e  reg_adr,
	input  logic [7:0]          reg_din,
	input  logic                reg_read,
	input  logic                reg_write,
	output logic [7:0]          reg_dout,
	output logic                irq_vblank,
	output logic                irq_stat,
	output logic [15:0]         adr,
	output logic                read,
	input  logic [7:0]          data,
	output logic                hsync,
	output logic                vsync,
	output logic                pclk,
	output logic [1:0]          px
);

	// Register file outputs
	logic       lcd_on;
	logic       bg_map;
	logic       bg_tiles;
	logic       sel_lyc;
	logic       sel_mode2;
	logic       sel_mode1;
	logic       sel_mode0;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;

	// Timing
	ppu_pkg::ppu_mode_e mode;
	logic [7:0]         ly;
	logic               lyc_eq;
	logic               lx_zero;

	// Fetcher to FIFO
	logic [7:0] row_lo;
	logic [7:0] row_hi;
	logic       row_valid;
	logic       row_take;
	logic       line_done;

	ppu_regs ppu_regs_inst (
		.clk(clk), .reset(reset),
		.reg_adr(reg_adr), .reg_din(reg_din), .reg_read(reg_read), .reg_write(reg_write),
		.ly(ly), .mode(mode), .lyc_eq(lyc_eq), .reg_dout(reg_dout),
		.lcd_on(lcd_on), .bg_map(bg_map), .bg_tiles(bg_tiles),
		.sel_lyc(sel_lyc), .sel_mode2(sel_mode2), .sel_mode1(sel_mode1), .sel_mode0(sel_mode0),
		.scy(scy), .scx(scx), .lyc(lyc), .bgp(bgp)
	);

	ppu_timing ppu_timing_inst (
		.clk(clk), .reset(reset), .lcd_on(lcd_on), .lyc(lyc),
		.sel_lyc(sel_lyc), .sel_mode2(sel_mode2), .sel_mode1(sel_mode1), .sel_mode0(sel_mode0),
		.line_done(line_done), .mode(mode), .ly(ly), .lyc_eq(lyc_eq), .lx_zero(lx_zero),
		.irq_vblank(irq_vblank), .irq_stat(irq_stat), .vsync(vsync)
	);

	ppu_fetch ppu_fetch_inst (
		.clk(clk), .reset(reset), .mode(mode), .ly(ly), .scy(scy), .scx(scx),
		.bg_map(bg_map), .bg_tiles(bg_tiles), .data(data), .row_take(row_take),
		.adr(adr), .read(read), .row_lo(row_lo), .row_hi(row_hi), .row_valid(row_valid)
	);

	ppu_fifo ppu_fifo_inst (
		.clk(clk), .reset(reset), .mode(mode), .scx(scx), .bgp(bgp),
		.row_lo(row_lo), .row_hi(row_hi), .row_valid(row_valid),
		.row_take(row_take), .line_done(line_done), .hsync(hsync), .pclk(pclk), .px(px)
	);

endmodule

// ==== ppu.f ====
hw/ppu_pkg.sv
hw/ppu_regs.sv
hw/ppu_timing.sv
hw/ppu_fetch.sv
hw/ppu_fifo.sv
hw/ppu_top.sv
sim/clock_gen.sv
sim/ppu_props.sv
sim/ppu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/1ps --top-module ppu_tb -f ppu.f -o ppu_sim \
	&& ./obj_dir/ppu_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^Test passed$" \
	|| { echo "Simulation did not pass"; exit 1; }

// ==== sim/clock_gen.sv ====
module clock_gen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== sim/ppu_props.sv ====
module ppu_props (
	input  logic                clk,
	input  logic                reset,
	input  ppu_pkg::reg_addr_e  reg_adr,
	input  logic [7:0]          reg_din,
	input  logic                reg_read,
	input  logic                reg_write,
	input  logic [7:0]          reg_dout,
	input  logic [7:0]          ly,
	input  ppu_pkg::ppu_mode_e  mode,
	input  logic                irq_vblank,
	input  logic                irq_stat,
	input  logic [15:0]         adr,
	input  logic                read,
	input  logic                hsync,
	input  logic                vsync,
	input  logic                pclk,
	input  logic [1:0]          px
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES = int'(ppu_pkg::LINE_CYCLES) * int'(ppu_pkg::FRAME_LINES);
	localparam int PIXELS_SHOWN = int'(ppu_pkg::LINE_PIXELS) - 8;

	logic [7:0]         shadow [16]; // Last byte written to each offset
	logic               read_q;
	logic               write_q;
	logic               rd_pend;
	logic [7:0]         exp_rd;
	logic [7:0]         rd_want;
	logic               lcd_sh;
	logic [7:0]         lyc_sh;
	logic [3:0]         sel_sh;
	logic [15:0]        map_sh;      // Tile map base picked by LCDC bit 3
	logic [15:0]        tile_sh;     // Rows of tile 0 for the LCDC bit 4 setting
	logic [7:0]         ly_q;
	logic               hsync_q;
	logic               vb_seen;
	logic               line_armed;  // A full line has been seen
	logic               pclk_armed;
	logic [1:0]         off_cnt;     // Cycles since the LCD was switched off
	ppu_pkg::ppu_mode_e mode_q;
	int                 gap;
	int                 oam_len;
	int                 pclk_cnt;

	// One counter per check
	int fail_rd = 0;
	int fail_gap = 0;
	int fail_pulse = 0;
	int fail_vbmode = 0;
	int fail_oam = 0;
	int fail_oamend = 0;
	int fail_pxend = 0;
	int fail_pclk = 0;
	int fail_px = 0;
	int fail_lyc = 0;
	int fail_off = 0;
	int fail_adr = 0;
	int fail_cnt;

	assign fail_cnt = fail_rd + fail_gap + fail_pulse + fail_vbmode + fail_oam +
		fail_oamend + fail_pxend + fail_pclk + fail_px + fail_lyc + fail_off + fail_adr;

	assign lcd_sh  = shadow[ppu_pkg::LCDC][7];
	assign lyc_sh  = shadow[ppu_pkg::LYC];
	assign sel_sh  = shadow[ppu_pkg::STAT][6:3];
	assign map_sh  = shadow[ppu_pkg::LCDC][3] ? 16'h9c00 : 16'h9800;
	assign tile_sh = shadow[ppu_pkg::LCDC][4] ? 16'h8000 : 16'h9000; // Index 0 signed is 9000

	//////////////////////////////////////////////////////////////////////
	// Expected register readback

	always_comb begin
		case (reg_adr)
			ppu_pkg::LCDC, ppu_pkg::SCY, ppu_pkg::SCX, ppu_pkg::LYC, ppu_pkg::BGP,
			ppu_pkg::OBP0, ppu_pkg::OBP1, ppu_pkg::WY, ppu_pkg::WX:
				exp_rd = shadow[reg_adr];
			ppu_pkg::STAT: exp_rd = {1'b1, sel_sh, lcd_sh && ly == lyc_sh, mode};
			ppu_pkg::LY:   exp_rd = lcd_sh ? ly : 8'h00; // Held at 0 while the LCD is off
			default:       exp_rd = 8'hff;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				shadow[i] <= 8'h00;
			read_q     <= 1'b0;
			write_q    <= 1'b0;
			rd_pend    <= 1'b0;
			rd_want    <= 8'h00;
			ly_q       <= 8'h00;
			hsync_q    <= 1'b0;
			mode_q     <= ppu_pkg::HBLANK;
			vb_seen    <= 1'b0;
			gap        <= 0;
			oam_len    <= 0;
			pclk_cnt   <= 0;
			pclk_armed <= 1'b0;
			line_armed <= 1'b0;
			off_cnt    <= 2'd0;
		end else begin
			read_q  <= reg_read;
			write_q <= reg_write;
			rd_pend <= reg_read && !read_q;
			if (reg_read && !read_q)
				rd_want <= exp_rd;
			if (write_q && !reg_write)
				shadow[reg_adr] <= reg_din; // Trailing edge of the write
			ly_q    <= ly;
			hsync_q <= hsync;
			mode_q  <= mode;
			oam_len <= (mode == ppu_pkg::OAMSRC) ? oam_len + 1 : 0;
			if (irq_vblank) begin
				vb_seen <= 1'b1;
				gap     <= 1;
			end else begin
				gap <= gap + 1;
			end
			if (hsync_q && !hsync) begin
				pclk_cnt   <= 0;
				pclk_armed <= 1'b1;
			end else if (pclk) begin
				pclk_cnt <= pclk_cnt + 1;
			end
			if (!lcd_sh)
				line_armed <= 1'b0;
			else if (mode_q == ppu_pkg::PXTRANS && mode == ppu_pkg::HBLANK)
				line_armed <= 1'b1;
			if (lcd_sh)
				off_cnt <= 2'd0;
			else if (off_cnt != 2'd3)
				off_cnt <= off_cnt + 2'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	rd_back: assert property (@(posedge clk) disable iff (reset)
		rd_pend |-> reg_dout == rd_want)
		else begin
			$error("[ERROR] %0t reg_dout %02h expected %02h", $time,
				$sampled(reg_dout), $sampled(rd_want));
			fail_rd++;
		end

	vb_gap: assert property (@(posedge clk) disable iff (reset)
		irq_vblank && vb_seen |-> gap == FRAME_CYCLES)
		else begin
			$error("[ERROR] %0t irq_vblank gap %0d expected %0d", $time,
				$sampled(gap), FRAME_CYCLES);
			fail_gap++;
		end

	vb_pulse: assert property (@(posedge clk) disable iff (reset)
		irq_vblank |=> !irq_vblank)
		else begin
			$error("irq_vblank stayed high for more than one cycle");
			fail_pulse++;
		end

	vb_mode: assert property (@(posedge clk) disable iff (reset)
		ly >= ppu_pkg::VISIBLE_LINES |-> mode == ppu_pkg::VBLANK)
		else begin
			$error("[ERROR] %0t mode %0d expected %0d", $time, $sampled(mode), ppu_pkg::VBLANK);
			fail_vbmode++;
		end

	oam_length: assert property (@(posedge clk) disable iff (reset || !lcd_sh)
		line_armed && mode == ppu_pkg::PXTRANS && mode_q == ppu_pkg::OAMSRC
		|-> oam_len == int'(ppu_pkg::OAMSRC_CYCLES))
		else begin
			$error("[ERROR] %0t oam_len %0d expected %0d", $time,
				$sampled(oam_len), ppu_pkg::OAMSRC_CYCLES);
			fail_oam++;
		end

	oam_exit: assert property (@(posedge clk) disable iff (reset || !lcd_sh)
		mode_q == ppu_pkg::OAMSRC && mode != ppu_pkg::OAMSRC |-> mode == ppu_pkg::PXTRANS)
		else begin
			$error("[ERROR] %0t mode %0d expected %0d", $time, $sampled(mode), ppu_pkg::PXTRANS);
			fail_oamend++;
		end

	pxtrans_exit: assert property (@(posedge clk) disable iff (reset || !lcd_sh)
		mode_q == ppu_pkg::PXTRANS && mode != ppu_pkg::PXTRANS |-> mode == ppu_pkg::HBLANK)
		else begin
			$error("[ERROR] %0t mode %0d expected %0d", $time, $sampled(mode), ppu_pkg::HBLANK);
			fail_pxend++;
		end

	pclk_count: assert property (@(posedge clk) disable iff (reset)
		pclk_armed && hsync && !hsync_q |-> pclk_cnt == PIXELS_SHOWN)
		else begin
			$error("[ERROR] %0t pclk_cnt %0d expected %0d", $time,
				$sampled(pclk_cnt), PIXELS_SHOWN);
			fail_pclk++;
		end

	px_value: assert property (@(posedge clk) disable iff (reset)
		pclk |-> px == shadow[ppu_pkg::BGP][3:2]) // Every tile pixel has index 1
		else begin
			$error("[ERROR] %0t px %0d expected %0d", $time, $sampled(px),
				$sampled(shadow[ppu_pkg::BGP][3:2]));
			fail_px++;
		end

	lyc_irq: assert property (@(posedge clk) disable iff (reset || !lcd_sh)
		sel_sh == 4'b1000 && ly == lyc_sh && ly_q != lyc_sh |=> irq_stat)
		else begin
			$error("irq_stat did not pulse in the cycle after LY reached LYC");
			fail_lyc++;
		end

	// Only map entries and rows of tile 0 are ever fetched
	vram_adr: assert property (@(posedge clk) disable iff (reset || !lcd_sh)
		read |-> adr[15:10] == map_sh[15:10] || adr[15:4] == tile_sh[15:4])
		else begin
			$error("VRAM read at %04h is outside the selected tile map and tile 0",
				$sampled(adr));
			fail_adr++;
		end

	off_quiet: assert property (@(posedge clk) disable iff (reset)
		off_cnt == 2'd3 |-> ly == 8'd0 && !hsync && !vsync && !pclk && !read &&
		!irq_vblank && !irq_stat)
		else begin
			$error("LCD outputs are active while LCDC bit 7 is clear");
			fail_off++;
		end

endmodule

bind ppu_top ppu_props ppu_props_inst (
	.clk(clk), .reset(reset), .reg_adr(reg_adr), .reg_din(reg_din),
	.reg_read(reg_read), .reg_write(reg_write), .reg_dout(reg_dout),
	.ly(ly), .mode(mode), .irq_vblank(irq_vblank), .irq_stat(irq_stat),
	.adr(adr), .read(read), .hsync(hsync), .vsync(vsync), .pclk(pclk), .px(px)
);

// ==== sim/ppu_tb.sv ====
module ppu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Two and a half frames
	localparam int MAX_CYCLES = 5 * int'(ppu_pkg::LINE_CYCLES) * int'(ppu_pkg::FRAME_LINES) / 2;

	logic               clk;
	logic               reset;
	ppu_pkg::reg_addr_e reg_adr;
	logic [7:0]         reg_din;
	logic               reg_read;
	logic               reg_write;
	logic [7:0]         reg_dout;
	logic               irq_vblank;
	logic               irq_stat;
	logic [15:0]        adr;
	logic               read;
	logic [7:0]         data = 8'h00;
	logic               hsync;
	logic               vsync;
	logic               pclk;
	logic [1:0]         px;
	logic [31:0]        rng = 32'hb1c0;
	int                 cycles = 0;

	clock_gen clock_gen_inst (.clk(clk), .reset(reset));

	ppu_top ppu_top_inst (
		.clk(clk), .reset(reset), .reg_adr(reg_adr), .reg_din(reg_din),
		.reg_read(reg_read), .reg_write(reg_write), .reg_dout(reg_dout),
		.irq_vblank(irq_vblank), .irq_stat(irq_stat), .adr(adr), .read(read), .data(data),
		.hsync(hsync), .vsync(vsync), .pclk(pclk), .px(px)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Map entries hold tile 0, tile rows are ff/00 so every pixel is index 1
	function automatic logic [7:0] vram_byte(input logic [15:0] a);
		if (a >= ppu_pkg::MAP_BASE_0)
			return 8'h00;
		return a[0] ? 8'h00 : 8'hff;
	endfunction

	always_ff @(posedge clk)
		if (read)
			data <= vram_byte(adr); // One cycle read latency

	task automatic write_reg(input logic [3:0] ofs, input logic [7:0] val);
		@(posedge clk);
		reg_adr   <= ppu_pkg::reg_addr_e'(ofs);
		reg_din   <= val;
		reg_write <= 1'b1;
		repeat (2) @(posedge clk);
		reg_write <= 1'b0; // Stored on this falling edge
	endtask

	task automatic read_reg(input logic [3:0] ofs);
		@(posedge clk);
		reg_adr  <= ppu_pkg::reg_addr_e'(ofs);
		reg_read <= 1'b1;
		repeat (2) @(posedge clk);
		reg_read <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int         off;
		logic [7:0] val;
		logic [7:0] lcdc_val;

		reg_adr   = ppu_pkg::LCDC;
		reg_din   = 8'h00;
		reg_read  = 1'b0;
		reg_write = 1'b0;
		lcdc_val  = 8'h00;
		do
			@(posedge clk);
		while (reset !== 1'b0);

		// Every offset, mapped or not, LY included
		for (off = 0; off < 16; off++) begin
			rng = xorshift(rng);
			val = rng[7:0];
			if (off == 0) begin
				val[7]   = 1'b0; // LCD stays off for now
				lcdc_val = val;
			end
			write_reg(off[3:0], val);
			read_reg(off[3:0]);
		end

		rng = xorshift(rng);
		write_reg(ppu_pkg::BGP, rng[7:0]);
		read_reg(ppu_pkg::BGP);
		rng = xorshift(rng);
		write_reg(ppu_pkg::SCX, rng[7:0]);
		read_reg(ppu_pkg::SCX);
		write_reg(ppu_pkg::LYC, 8'd10);
		read_reg(ppu_pkg::LYC);
		write_reg(ppu_pkg::STAT, 8'h40); // LYC source only
		read_reg(ppu_pkg::STAT);
		write_reg(ppu_pkg::LCDC, lcdc_val | 8'h80);

		// Line 10 starts, STAT bit 2 should be set
		while (!irq_stat)
			@(posedge clk);
		read_reg(ppu_pkg::STAT);
		read_reg(ppu_pkg::LY);

		// Two vblanks give one full frame gap
		repeat (2) begin
			do
				@(posedge clk);
			while (!irq_vblank);
		end

		write_reg(ppu_pkg::LCDC, lcdc_val & 8'h7f);
		repeat (8) @(posedge clk);
		read_reg(ppu_pkg::LY);
		read_reg(ppu_pkg::STAT);
		repeat (8) @(posedge clk);

		$display("Summary: %0d assertion failures in %0d cycles",
			ppu_top_inst.ppu_props_inst.fail_cnt, cycles);
		if (ppu_top_inst.ppu_props_inst.fail_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

endmodule
